// File: source/nts_stats_pkg.sv
package nts_stats_pkg;

  // ------------------------------------------------
  // Widths
  // ------------------------------------------------
  localparam int API_DATA_WIDTH  = 32;
  localparam int API_ADDR_WIDTH  = 12;
  localparam int WORD_ADDR_WIDTH = 8;
  localparam int BLOCK_SEL_WIDTH = API_ADDR_WIDTH - WORD_ADDR_WIDTH;
  localparam int COUNTER_WIDTH   = 64;
  localparam int NUM_COUNTERS    = 6;

  // ------------------------------------------------
  // Address map
  // ------------------------------------------------
  localparam logic [BLOCK_SEL_WIDTH-1:0] BLOCK_ENGINE = 4'h0;
  localparam logic [BLOCK_SEL_WIDTH-1:0] BLOCK_DEBUG  = 4'h1;

  // Engine block words
  localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_ENGINE_NAME0   = 8'h00;
  localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_ENGINE_NAME1   = 8'h01;
  localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_ENGINE_VERSION = 8'h02;
  localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_ENGINE_CTRL    = 8'h08;

  // Debug block words
  localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_DEBUG_NAME    = 8'h08;
  localparam logic [WORD_ADDR_WIDTH-1:0] ADDR_DEBUG_SYSTICK = 8'h09;

  // ------------------------------------------------
  // Identity words
  // ------------------------------------------------
  localparam logic [API_DATA_WIDTH-1:0] ENGINE_NAME0      = 32'h4e_54_53_5f; // "NTS_"
  localparam logic [API_DATA_WIDTH-1:0] ENGINE_NAME1      = 32'h45_4e_47_4e; // "ENGN"
  localparam logic [API_DATA_WIDTH-1:0] ENGINE_VERSION    = 32'h30_2e_30_31; // "0.01"
  localparam logic [API_DATA_WIDTH-1:0] ENGINE_CTRL_VALUE = 32'h0000_0001;
  localparam logic [API_DATA_WIDTH-1:0] DEBUG_NAME        = 32'h44_42_55_47; // "DBUG"

  // Counter order matches the event vector bits
  typedef enum logic [2:0] {
    STAT_PROCESSED,
    STAT_BAD_COOKIE,
    STAT_BAD_AUTH,
    STAT_BAD_KEYID,
    STAT_ERR_CRYPTO,
    STAT_ERR_TXBUF
  } stat_id_e;

  // High word of each counter, low word sits one above
  localparam logic [WORD_ADDR_WIDTH-1:0] COUNTER_BASE [NUM_COUNTERS] = '{
    8'h00, 8'h02, 8'h04, 8'h06, 8'h20, 8'h22
  };

  // ------------------------------------------------
  // Structs
  // ------------------------------------------------
  typedef struct packed {
    logic                      cs;
    logic                      we;
    logic [API_ADDR_WIDTH-1:0] address;
    logic [API_DATA_WIDTH-1:0] write_data; // Accepted, never stored
  } api_req_t;

  typedef enum logic [2:0] {
    RD_NONE,
    RD_ENGINE_WORD,
    RD_DEBUG_NAME,
    RD_SYSTICK,
    RD_COUNTER_HI,
    RD_COUNTER_LO
  } rd_kind_e;

  typedef struct packed {
    rd_kind_e                   kind;
    stat_id_e                   counter;
    logic [WORD_ADDR_WIDTH-1:0] word;
  } rd_sel_t;

  typedef struct packed {
    logic [API_DATA_WIDTH-1:0] hi;      // Live upper half
    logic [API_DATA_WIDTH-1:0] lo_snap; // Lower half held at the last high read
  } counter_view_t;

endpackage

// File: source/nts_api_decode.sv
`timescale 1ns/100ps

module nts_api_decode (
  input  nts_stats_pkg::api_req_t                   i_req,
  output nts_stats_pkg::rd_sel_t                    o_sel,
  output logic [nts_stats_pkg::NUM_COUNTERS-1:0]    o_snapshot
);

  logic                                        is_read;
  logic [nts_stats_pkg::BLOCK_SEL_WIDTH-1:0]   block;
  logic [nts_stats_pkg::WORD_ADDR_WIDTH-1:0]   word;

  assign is_read = i_req.cs && !i_req.we; // Writes are ignored
  assign block   = i_req.address[nts_stats_pkg::API_ADDR_WIDTH-1:
                                 nts_stats_pkg::WORD_ADDR_WIDTH];
  assign word    = i_req.address[nts_stats_pkg::WORD_ADDR_WIDTH-1:0];

  // ------------------------------------------------
  // Address match
  // ------------------------------------------------
  always_comb
  begin
    o_sel.kind    = nts_stats_pkg::RD_NONE;
    o_sel.counter = nts_stats_pkg::STAT_PROCESSED;
    o_sel.word    = word;
    o_snapshot    = '0;

    if (is_read)
    begin
      if (block == nts_stats_pkg::BLOCK_ENGINE)
      begin
        o_sel.kind = nts_stats_pkg::RD_ENGINE_WORD; // Word picked in read-back
      end
      else if (block == nts_stats_pkg::BLOCK_DEBUG)
      begin
        if (word == nts_stats_pkg::ADDR_DEBUG_NAME)
        begin
          o_sel.kind = nts_stats_pkg::RD_DEBUG_NAME;
        end
        else if (word == nts_stats_pkg::ADDR_DEBUG_SYSTICK)
        begin
          o_sel.kind = nts_stats_pkg::RD_SYSTICK;
        end

        for (int i = 0; i < nts_stats_pkg::NUM_COUNTERS; i++)
        begin
          if (word == nts_stats_pkg::COUNTER_BASE[i])
          begin
            // High word read also latches the low half
            o_sel.kind    = nts_stats_pkg::RD_COUNTER_HI;
            o_sel.counter = nts_stats_pkg::stat_id_e'(i);
            o_snapshot[i] = 1'b1;
          end
          else if (word == nts_stats_pkg::COUNTER_BASE[i] + 8'd1)
          begin
            o_sel.kind    = nts_stats_pkg::RD_COUNTER_LO;
            o_sel.counter = nts_stats_pkg::stat_id_e'(i);
          end
        end
      end
    end
  end

  // Counter bases must never overlap
  a_snapshot_onehot0: assert final ($onehot0(o_snapshot))
    else $error("More than one snapshot strobe raised");

endmodule

// File: source/nts_event_counter.sv
`timescale 1ns/100ps

module nts_event_counter (
  input  logic                         i_clk,
  input  logic                         i_areset,
  input  logic                         i_event,    // One-cycle pulse, count one
  input  logic                         i_snapshot, // High word is being read
  output nts_stats_pkg::counter_view_t o_view
);

  logic [nts_stats_pkg::COUNTER_WIDTH-1:0]  count;
  logic [nts_stats_pkg::API_DATA_WIDTH-1:0] lo_snap;

  // ------------------------------------------------
  // Count and snapshot
  // ------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      count   <= '0;
      lo_snap <= '0;
    end
    else
    begin
      if (i_event)
      begin
        count <= count + 1'b1;
      end
      // Takes the value before this cycle's event
      if (i_snapshot)
      begin
        lo_snap <= count[nts_stats_pkg::API_DATA_WIDTH-1:0];
      end
    end
  end

  assign o_view.hi      = count[nts_stats_pkg::COUNTER_WIDTH-1 -: nts_stats_pkg::API_DATA_WIDTH];
  assign o_view.lo_snap = lo_snap;

  // Strobes come from the top level and the decoder
  a_inputs_known: assert property (
    @(posedge i_clk) disable iff (i_areset)
    !$isunknown({i_event, i_snapshot})
  ) else $error("Event or snapshot strobe unknown");

endmodule

// File: source/nts_api_readback.sv
`timescale 1ns/100ps

module nts_api_readback (
  input  logic                                      i_clk,
  input  logic                                      i_areset,
  input  nts_stats_pkg::rd_sel_t                    i_sel,
  input  nts_stats_pkg::counter_view_t              i_views [nts_stats_pkg::NUM_COUNTERS],
  output logic [nts_stats_pkg::API_DATA_WIDTH-1:0]  o_read_data
);

  logic [nts_stats_pkg::API_DATA_WIDTH-1:0] systick;
  logic [nts_stats_pkg::API_DATA_WIDTH-1:0] engine_word;

  // ------------------------------------------------
  // System tick
  // ------------------------------------------------
  always_ff @(posedge i_clk or posedge i_areset)
  begin
    if (i_areset)
    begin
      systick <= 32'h0000_0001; // First cycle out of reset reads 1
    end
    else
    begin
      systick <= systick + 1'b1; // Wraps at 2^32
    end
  end

  // ------------------------------------------------
  // Engine identity words
  // ------------------------------------------------
  always_comb
  begin
    case (i_sel.word)
      nts_stats_pkg::ADDR_ENGINE_NAME0:
      begin
        engine_word = nts_stats_pkg::ENGINE_NAME0;
      end
      nts_stats_pkg::ADDR_ENGINE_NAME1:
      begin
        engine_word = nts_stats_pkg::ENGINE_NAME1;
      end
      nts_stats_pkg::ADDR_ENGINE_VERSION:
      begin
        engine_word = nts_stats_pkg::ENGINE_VERSION;
      end
      nts_stats_pkg::ADDR_ENGINE_CTRL:
      begin
        engine_word = nts_stats_pkg::ENGINE_CTRL_VALUE;
      end
      default:
      begin
        engine_word = '0; // Unmapped engine word
      end
    endcase
  end

  // ------------------------------------------------
  // Read data mux
  // ------------------------------------------------
  always_comb
  begin
    case (i_sel.kind)
      nts_stats_pkg::RD_ENGINE_WORD:
      begin
        o_read_data = engine_word;
      end
      nts_stats_pkg::RD_DEBUG_NAME:
      begin
        o_read_data = nts_stats_pkg::DEBUG_NAME;
      end
      nts_stats_pkg::RD_SYSTICK:
      begin
        o_read_data = systick;
      end
      nts_stats_pkg::RD_COUNTER_HI:
      begin
        o_read_data = i_views[i_sel.counter].hi;
      end
      nts_stats_pkg::RD_COUNTER_LO:
      begin
        o_read_data = i_views[i_sel.counter].lo_snap; // Held since the last high read
      end
      default:
      begin
        o_read_data = '0; // No read, write cycle or unmapped
      end
    endcase
  end

  a_idle_reads_zero: assert property (
    @(posedge i_clk) disable iff (i_areset)
    (i_sel.kind == nts_stats_pkg::RD_NONE) |-> (o_read_data == '0)
  ) else $error("Read data not zero without a decoded read");

endmodule

// File: source/nts_engine_stats.sv
`timescale 1ns/100ps

module nts_engine_stats (
  input  logic                                      i_clk,
  input  logic                                      i_areset,
  input  nts_stats_pkg::api_req_t                   i_api_req,
  input  logic [nts_stats_pkg::NUM_COUNTERS-1:0]    i_events, // Indexed by stat_id_e
  output logic [nts_stats_pkg::API_DATA_WIDTH-1:0]  o_api_read_data
);

  nts_stats_pkg::rd_sel_t                  rd_sel;
  logic [nts_stats_pkg::NUM_COUNTERS-1:0]  snapshot;
  nts_stats_pkg::counter_view_t            views [nts_stats_pkg::NUM_COUNTERS];

  // ------------------------------------------------
  // Host address decode
  // ------------------------------------------------
  nts_api_decode u_decode (
    .i_req      (i_api_req),
    .o_sel      (rd_sel),
    .o_snapshot (snapshot)
  );

  // ------------------------------------------------
  // Event counters
  // ------------------------------------------------
  for (genvar g = 0; g < nts_stats_pkg::NUM_COUNTERS; g++)
  begin : g_counter
    nts_event_counter u_counter (
      .i_clk      (i_clk),
      .i_areset   (i_areset),
      .i_event    (i_events[g]),
      .i_snapshot (snapshot[g]),
      .o_view     (views[g])
    );
  end

  // ------------------------------------------------
  // Read-back
  // ------------------------------------------------
  nts_api_readback u_readback (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_sel       (rd_sel),
    .i_views     (views),
    .o_read_data (o_api_read_data)
  );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 10
) (
  output logic o_clk,
  output logic o_areset
);

  initial
  begin
    o_clk    = 1'b0;
    o_areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_areset = 1'b0; // Released on a falling edge
  end

  always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

// File: dv/tb_stats_cases.svh
task automatic load_cases();
  // Columns are operation, operand, expected value, use model and repeats
  // Counter and tick reads carry the counter in operand [3:0] and an event mask in [13:8]
  add_case(OP_CHECK_ALL, 32'h0000, 32'h0000_0000, 1'b0, 1); // Reset state

  // Identity words and quiet cycles
  add_case(OP_READ,  32'h0000, 32'h4e54_535f, 1'b0, 1);
  add_case(OP_READ,  32'h0001, 32'h454e_474e, 1'b0, 1);
  add_case(OP_READ,  32'h0002, 32'h302e_3031, 1'b0, 1);
  add_case(OP_READ,  32'h0008, 32'h0000_0001, 1'b0, 1);
  add_case(OP_READ,  32'h0108, 32'h4442_5547, 1'b0, 1);
  add_case(OP_READ,  32'h0010, 32'h0000_0000, 1'b0, 1); // Unmapped engine word
  add_case(OP_READ,  32'h01ff, 32'h0000_0000, 1'b0, 1);
  add_case(OP_READ,  32'h0300, 32'h0000_0000, 1'b0, 1); // Unmapped block
  add_case(OP_NOCS,  32'h0000, 32'h0000_0000, 1'b0, 1);
  add_case(OP_WRITE, 32'h0108, 32'h0000_0000, 1'b0, 1);

  // Counting
  add_case(OP_EVENT,     32'h01, 32'h0, 1'b0, 3);
  add_case(OP_EVENT,     32'h06, 32'h0, 1'b0, 2);
  add_case(OP_IDLE,      32'h00, 32'h0, 1'b0, 2);
  add_case(OP_EVENT,     32'h3f, 32'h0, 1'b0, 1);
  add_case(OP_EVENT,     32'h30, 32'h0, 1'b0, 5);
  add_case(OP_EVENT,     32'h08, 32'h0, 1'b0, 1);
  add_case(OP_CHECK_ALL, 32'h00, 32'h0, 1'b1, 1);

  // Snapshot coherency on counter 1
  add_case(OP_READ_HI, 32'h0001, 32'h0, 1'b1, 1);
  add_case(OP_EVENT,   32'h0002, 32'h0, 1'b0, 4);
  add_case(OP_READ_LO, 32'h0001, 32'h0, 1'b1, 1);
  add_case(OP_WRITE,   32'h0102, 32'h0, 1'b0, 1); // Write takes no snapshot
  add_case(OP_EVENT,   32'h0002, 32'h0, 1'b0, 1);
  add_case(OP_READ_LO, 32'h0001, 32'h0, 1'b1, 1); // Same old snapshot
  add_case(OP_READ_HI, 32'h0201, 32'h0, 1'b1, 1); // Event in the read cycle
  add_case(OP_READ_LO, 32'h0001, 32'h0, 1'b1, 1);

  // System tick
  add_case(OP_TICK, 32'h0000, 32'h0, 1'b1, 1);
  add_case(OP_IDLE, 32'h0000, 32'h0, 1'b0, 5);
  add_case(OP_TICK, 32'h0000, 32'h0, 1'b0, 2); // Step from the previous tick read
endtask

// File: dv/tb_nts_engine_stats.sv
`timescale 1ns/100ps

module tb_nts_engine_stats;

  localparam int CLK_PERIOD_NS = 8;
  localparam int RANDOM_CYCLES = 200;
  localparam int NUM_COUNTERS  = nts_stats_pkg::NUM_COUNTERS;

  typedef enum {
    OP_IDLE, OP_EVENT, OP_READ, OP_WRITE, OP_NOCS,
    OP_READ_HI, OP_READ_LO, OP_TICK, OP_CHECK_ALL
  } op_e;

  typedef struct {
    op_e         op;
    logic [31:0] operand;
    logic [31:0] expected;
    bit          use_model;
    int          repeats;
  } case_t;

  logic                    clk;
  logic                    areset;
  nts_stats_pkg::api_req_t api_req;
  logic [NUM_COUNTERS-1:0] events;
  logic [31:0]             read_data;

  case_t       cases [$];
  bit          cases_loaded = 1'b0;
  bit          failed       = 1'b0;
  logic [63:0] model_count [NUM_COUNTERS];
  logic [31:0] model_snap  [NUM_COUNTERS];
  logic [31:0] elapsed_cycles = '0; // Rising edges since reset release
  bit          have_tick = 1'b0;
  logic [31:0] last_tick;
  logic [31:0] last_tick_cycle;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS), .RESET_CYCLES(10)) u_clock_gen (
    .o_clk    (clk),
    .o_areset (areset)
  );

  nts_engine_stats u_nts_engine_stats (
    .i_clk           (clk),
    .i_areset        (areset),
    .i_api_req       (api_req),
    .i_events        (events),
    .o_api_read_data (read_data)
  );

  always @(posedge clk)
  begin
    if (!areset)
    begin
      elapsed_cycles <= elapsed_cycles + 1;
    end
  end

  // ------------------------------------------------
  // Table and helpers
  // ------------------------------------------------
  task automatic add_case(input op_e op, input logic [31:0] operand,
                          input logic [31:0] expected, input bit use_model, input int repeats);
    case_t c;
    c.op        = op;
    c.operand   = operand;
    c.expected  = expected;
    c.use_model = use_model;
    c.repeats   = repeats;
    cases.push_back(c);
  endtask

  `include "tb_stats_cases.svh"

  function automatic logic [11:0] hi_address(input int idx);
    case (idx)
      0:       return 12'h100;
      1:       return 12'h102;
      2:       return 12'h104;
      3:       return 12'h106;
      4:       return 12'h120;
      default: return 12'h122;
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int planned_cycles();
    int total;
    total = RANDOM_CYCLES + 2 * NUM_COUNTERS;
    foreach (cases[n])
    begin
      total += cases[n].repeats * ((cases[n].op == OP_CHECK_ALL) ? 2 * NUM_COUNTERS : 1);
    end
    return total;
  endfunction

  task automatic report_failure();
    failed = 1'b1;
    $display("Some tests failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_read(input logic [31:0] want);
    assert (read_data === want)
    else
    begin
      $display("Fail at %0d ns: o_api_read_data expected %h, got %h", $time, want, read_data);
      report_failure();
    end
  endtask

  // ------------------------------------------------
  // One bus cycle with its model update
  // ------------------------------------------------
  task automatic apply_cycle(input op_e op, input logic [31:0] operand,
                             input logic [31:0] expected, input bit use_model);
    logic [31:0] want;
    int          idx;
    idx = int'(operand[3:0]);
    @(negedge clk);
    api_req = '0;
    events  = '0;
    want    = expected;
    case (op)
      OP_EVENT: events = operand[NUM_COUNTERS-1:0];
      OP_READ, OP_WRITE, OP_NOCS:
      begin
        api_req.cs         = (op != OP_NOCS);
        api_req.we         = (op == OP_WRITE);
        api_req.address    = operand[11:0];
        api_req.write_data = 32'ha5a5_5a5a; // Must be ignored
      end
      OP_READ_HI, OP_READ_LO, OP_TICK:
      begin
        api_req.cs      = 1'b1;
        api_req.address = (op == OP_TICK) ? 12'h109 : hi_address(idx) + (op == OP_READ_LO);
        events          = operand[8 +: NUM_COUNTERS];
        if (use_model)
        begin
          want = (op == OP_TICK)    ? 32'd1 + elapsed_cycles :
                 (op == OP_READ_HI) ? model_count[idx][63:32] : model_snap[idx];
        end
      end
      default: ;
    endcase
    #(CLK_PERIOD_NS / 2 - 1); // Just before the rising edge
    if (op != OP_EVENT && op != OP_IDLE && (op != OP_TICK || use_model))
    begin
      check_read(want);
    end
    if (op == OP_TICK)
    begin
      if (have_tick)
      begin
        assert (read_data - last_tick == elapsed_cycles - last_tick_cycle)
        else
        begin
          $display("Fail at %0d ns: o_api_read_data tick step expected %0d, got %0d",
                   $time, elapsed_cycles - last_tick_cycle, read_data - last_tick);
          report_failure();
        end
      end
      have_tick       = 1'b1;
      last_tick       = read_data;
      last_tick_cycle = elapsed_cycles;
    end
    @(posedge clk);
    if (op == OP_READ_HI)
    begin
      model_snap[idx] = model_count[idx][31:0]; // Before this cycle's event
    end
    for (int i = 0; i < NUM_COUNTERS; i++)
    begin
      if (events[i])
      begin
        model_count[i] = model_count[i] + 1;
      end
    end
  endtask

  task automatic run_case(input case_t c);
    for (int r = 0; r < c.repeats; r++)
    begin
      if (c.op == OP_CHECK_ALL)
      begin
        for (int i = 0; i < NUM_COUNTERS; i++)
        begin
          apply_cycle(OP_READ_HI, i, c.expected, c.use_model);
          apply_cycle(OP_READ_LO, i, c.expected, c.use_model);
        end
      end
      else
      begin
        apply_cycle(c.op, c.operand, c.expected, c.use_model);
      end
    end
  endtask

  // ------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------
  initial
  begin : main
    logic [31:0] rng;
    case_t       readout;
    api_req = '0;
    events  = '0;
    foreach (model_count[i])
    begin
      model_count[i] = '0;
      model_snap[i]  = '0;
    end
    load_cases();
    cases_loaded = 1'b1;
    @(negedge areset);
    foreach (cases[n])
    begin
      run_case(cases[n]);
    end
    rng = 32'd9636;
    repeat (RANDOM_CYCLES)
    begin
      rng = xorshift32(rng);
      apply_cycle(OP_EVENT, {26'd0, rng[5:0]}, '0, 1'b0);
    end
    readout.op        = OP_CHECK_ALL;
    readout.operand   = '0;
    readout.expected  = '0;
    readout.use_model = 1'b1;
    readout.repeats   = 1;
    run_case(readout);
    if (!failed)
    begin
      $display("All tests passed");
      $finish;
    end
    else
    begin
      report_failure();
    end
  end

  initial
  begin : watchdog
    longint budget_ns;
    wait (cases_loaded);
    budget_ns = longint'(planned_cycles()) * 4 * CLK_PERIOD_NS + 1000;
    #(budget_ns);
    $display("Timeout: the run did not finish within %0d ns", budget_ns);
    report_failure();
  end

endmodule

// File: src.f
+incdir+dv
source/nts_stats_pkg.sv
source/nts_api_decode.sv
source/nts_event_counter.sv
source/nts_api_readback.sv
source/nts_engine_stats.sv
dv/tb_clock_gen.sv
dv/tb_nts_engine_stats.sv
